//--- Bender.yml
package:
  name: duc_chain

export_include_dirs:
  - .

sources:
  - files:
      - logic/duc_pkg.sv
      - logic/duc_cfg_if.sv
      - logic/duc_settings.sv
      - logic/cic_interp.sv
      - logic/duc_nco.sv
      - logic/duc_mixer.sv
      - logic/duc_chain.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_duc_chain.sv

//--- duc_chain.f
+incdir+.
+incdir+tb
logic/duc_pkg.sv
logic/duc_cfg_if.sv
logic/duc_settings.sv
logic/cic_interp.sv
logic/duc_nco.sv
logic/duc_mixer.sv
logic/duc_chain.sv
tb/tb_duc_chain.sv

//--- duc_params.svh
/*
 * Build constants for the up-conversion chain: settings base address,
 * CIC and CORDIC depths, largest rate exponent and front-end width
 */
`ifndef DUC_PARAMS_SVH
`define DUC_PARAMS_SVH

// Register address is this base plus the enum offset
`define DUC_BASE 8'd0

`define DUC_CIC_STAGES 3      // Comb and integrator pairs
`define DUC_MAX_LOG2 6        // Rate 64 at most

`define DUC_CORDIC_STAGES 16  // Rotation pipeline depth

`define DUC_OUT_W 16          // TX front-end sample width

`endif

//--- logic/cic_interp.sv
/*
 * Input sample strobe and three-stage I/Q CIC interpolator,
 * DC gain removed by an exact rate-dependent shift
 */
`timescale 1ns/1ns
`include "duc_params.svh"

module cic_interp (
   input  logic           clk,
   input  logic           rst,
   duc_cfg_if.interp      cfg,
   input  duc_pkg::iq_t   sample_i,
   output logic           strobe_o,
   output duc_pkg::wide_t interp_i_o,
   output duc_pkg::wide_t interp_q_o
);

   localparam int N  = `DUC_CIC_STAGES;
   localparam int GB = (N - 1) * `DUC_MAX_LOG2;  // Growth of R^(N-1) at the top rate
   localparam int W  = $bits(duc_pkg::sample_t) + GB;

   logic [`DUC_MAX_LOG2-1:0] cnt;      // Position inside one input period
   logic [`DUC_MAX_LOG2-1:0] mask;     // Period minus one
   logic [4:0]               shift_r;  // Gain removal shift of (N-1) * rate_log2

   logic signed [W-1:0] comb  [2][N+1];  // Index 0 is I and 1 is Q
   logic signed [W-1:0] dly   [2][N];    // Comb delay lines
   logic signed [W-1:0] up_r  [2];       // Zero-stuffed comb output
   logic signed [W-1:0] integ [2][N];
   logic signed [W-1:0] norm  [2];
   duc_pkg::wide_t      out_r [2];

   assign mask = ~({`DUC_MAX_LOG2{1'b1}} << cfg.rate_log2);

   // Strobe counter giving one pulse per 2^rate_log2 clocks
   always_ff @(posedge clk) begin
      if (rst || !cfg.enable) begin
         cnt      <= '0;
         strobe_o <= 1'b0;
      end else begin
         cnt      <= (cnt + 1'b1) & mask;
         strobe_o <= (cnt == '0);  // First pulse right after enable rises
      end
   end

   // Shift follows the rate only while the state is being cleared
   always_ff @(posedge clk) begin
      if (rst)
         shift_r <= '0;
      else if (cfg.rate_change)
         shift_r <= 5'((N - 1) * cfg.rate_log2);
   end

   // Comb chain runs at the input rate on the held sample
   always_comb begin
      comb[0][0] = W'(sample_i.i);  // Sign extension into the guard bits
      comb[1][0] = W'(sample_i.q);
      for (int ch = 0; ch < 2; ch++) begin
         for (int k = 0; k < N; k++)
            comb[ch][k+1] = comb[ch][k] - dly[ch][k];
      end
   end

   always_ff @(posedge clk) begin
      if (rst || !cfg.enable) begin
         for (int ch = 0; ch < 2; ch++) begin
            up_r[ch] <= '0;
            for (int k = 0; k < N; k++) begin
               dly[ch][k]   <= '0;
               integ[ch][k] <= '0;
            end
         end
      end else begin
         for (int ch = 0; ch < 2; ch++) begin
            if (strobe_o) begin  // Sample captured on this edge
               for (int k = 0; k < N; k++)
                  dly[ch][k] <= comb[ch][k];
            end
            up_r[ch] <= strobe_o ? comb[ch][N] : '0;
            // Integrators run at the clock rate and wrap modulo 2^W
            integ[ch][0] <= integ[ch][0] + up_r[ch];
            for (int k = 1; k < N; k++)
               integ[ch][k] <= integ[ch][k] + integ[ch][k-1];
         end
      end
   end

   always_comb begin
      for (int ch = 0; ch < 2; ch++)
         norm[ch] = integ[ch][N-1] >>> shift_r;  // Gain back to exactly 1
   end

   // Output register updates on every clock
   always_ff @(posedge clk) begin
      if (rst) begin
         out_r[0] <= '0;
         out_r[1] <= '0;
      end else begin
         out_r[0] <= duc_pkg::wide_t'(norm[0]);
         out_r[1] <= duc_pkg::wide_t'(norm[1]);
      end
   end

   assign interp_i_o = out_r[0];
   assign interp_q_o = out_r[1];

endmodule

//--- logic/duc_cfg_if.sv
/*
 * Decoded chain configuration from the settings block to the datapath
 */
`timescale 1ns/1ns

interface duc_cfg_if;

   duc_pkg::phase_t phase_inc;   // Carrier step
   logic [17:0]     scale;       // Output gain
   logic [2:0]      rate_log2;   // Interpolation exponent
   logic            rate_change; // One-cycle pulse on an SR_RATE write
   logic            enable;      // Run and no rate change in progress

   // Settings side owns every signal
   modport ctrl (output phase_inc, scale, rate_log2, rate_change, enable);

   // Datapath views
   modport interp (input rate_log2, rate_change, enable);
   modport carrier (input phase_inc, enable);
   modport mix (input scale);

endinterface

//--- logic/duc_chain.sv
/*
 * Transmit up-conversion chain top level
 * Settings, CIC interpolator, carrier NCO and mixer
 */
`timescale 1ns/1ns
`include "duc_params.svh"

module duc_chain (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  set_stb_i,
   input  logic [7:0]            set_addr_i,
   input  logic [31:0]           set_data_i,
   input  logic [31:0]           sample_i,   // I upper, Q lower
   input  logic                  run_i,
   output logic                  strobe_o,   // Present the next sample before this edge
   output logic [`DUC_OUT_W-1:0] tx_i_o,
   output logic [`DUC_OUT_W-1:0] tx_q_o
);

   duc_cfg_if cfg ();

   duc_pkg::wide_t interp_i, interp_q;        // Signal at the clock rate
   duc_pkg::wide_t carrier_cos, carrier_sin;

   duc_settings u_settings (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .run_i      (run_i),
      .cfg        (cfg.ctrl)
   );

   cic_interp u_interp (
      .clk        (clk),
      .rst        (rst),
      .cfg        (cfg.interp),
      .sample_i   (duc_pkg::iq_t'(sample_i)),
      .strobe_o   (strobe_o),
      .interp_i_o (interp_i),
      .interp_q_o (interp_q)
   );

   duc_nco u_nco (
      .clk   (clk),
      .rst   (rst),
      .cfg   (cfg.carrier),
      .cos_o (carrier_cos),
      .sin_o (carrier_sin)
   );

   duc_mixer u_mixer (
      .clk        (clk),
      .rst        (rst),
      .cfg        (cfg.mix),
      .interp_i_i (interp_i),
      .interp_q_i (interp_q),
      .cos_i      (carrier_cos),
      .sin_i      (carrier_sin),
      .tx_i_o     (tx_i_o),
      .tx_q_o     (tx_q_o)
   );

endmodule

//--- logic/duc_mixer.sv
/*
 * Complex mixer of interpolated signal and carrier, then gain,
 * round to nearest and saturation to the front-end width
 */
`timescale 1ns/1ns
`include "duc_params.svh"

module duc_mixer (
   input  logic             clk,
   input  logic             rst,
   duc_cfg_if.mix           cfg,
   input  duc_pkg::wide_t   interp_i_i,
   input  duc_pkg::wide_t   interp_q_i,
   input  duc_pkg::wide_t   cos_i,
   input  duc_pkg::wide_t   sin_i,
   output duc_pkg::sample_t tx_i_o,
   output duc_pkg::sample_t tx_q_o
);

   localparam logic signed [23:0] SAT_MAX = 24'sd2 ** (`DUC_OUT_W - 1) - 24'sd1;
   localparam logic signed [23:0] SAT_MIN = -(24'sd2 ** (`DUC_OUT_W - 1));

   logic signed [36:0] mix_i, mix_q;      // Full complex products
   logic signed [20:0] mix_i_r, mix_q_r;  // After 16 fraction bits dropped
   logic signed [18:0] gain;              // Scale as a positive signed operand
   logic signed [39:0] prod_i, prod_q;
   logic signed [23:0] rnd_i, rnd_q;

   // (I + jQ) * (cos + j sin)
   assign mix_i = interp_i_i * cos_i - interp_q_i * sin_i;
   assign mix_q = interp_i_i * sin_i + interp_q_i * cos_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         mix_i_r <= '0;
         mix_q_r <= '0;
      end else begin
         mix_i_r <= mix_i[36:16];  // Carrier amplitude is 2^16
         mix_q_r <= mix_q[36:16];
      end
   end

   assign gain   = $signed({1'b0, cfg.scale});
   assign prod_i = mix_i_r * gain;
   assign prod_q = mix_q_r * gain;

   // Add half an LSB, then floor
   assign rnd_i = 24'((prod_i + 40'sd32768) >>> 16);
   assign rnd_q = 24'((prod_q + 40'sd32768) >>> 16);

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_i_o <= '0;
         tx_q_o <= '0;
      end else begin
         if (rnd_i > SAT_MAX)
            tx_i_o <= duc_pkg::sample_t'(SAT_MAX);
         else if (rnd_i < SAT_MIN)
            tx_i_o <= duc_pkg::sample_t'(SAT_MIN);
         else
            tx_i_o <= duc_pkg::sample_t'(rnd_i);
         if (rnd_q > SAT_MAX)
            tx_q_o <= duc_pkg::sample_t'(SAT_MAX);
         else if (rnd_q < SAT_MIN)
            tx_q_o <= duc_pkg::sample_t'(SAT_MIN);
         else
            tx_q_o <= duc_pkg::sample_t'(rnd_q);
      end
   end

endmodule

//--- logic/duc_nco.sv
/*
 * Carrier NCO: phase accumulator, quadrant fold and pipelined CORDIC
 * rotation giving cosine and sine at an amplitude of 2^16
 */
`timescale 1ns/1ns
`include "duc_params.svh"

module duc_nco (
   input  logic           clk,
   input  logic           rst,
   duc_cfg_if.carrier     cfg,
   output duc_pkg::wide_t cos_o,
   output duc_pkg::wide_t sin_o
);

   localparam int NS = `DUC_CORDIC_STAGES;
   localparam int XW = 20;  // 18-bit result plus 2 fraction bits

   // 4 * 2^16 divided by the CORDIC gain 1.64676
   localparam logic signed [XW-1:0] X_INIT = 20'sd159188;

   // atan(2^-k) with the full circle as 2^32
   function automatic duc_pkg::phase_t atan_tab(input int k);
      case (k)
         0:       atan_tab = 32'd536870912;  // 45 deg
         1:       atan_tab = 32'd316933406;
         2:       atan_tab = 32'd167458907;
         3:       atan_tab = 32'd85004756;
         4:       atan_tab = 32'd42667331;
         5:       atan_tab = 32'd21354465;
         6:       atan_tab = 32'd10679838;
         7:       atan_tab = 32'd5340245;
         8:       atan_tab = 32'd2670163;
         9:       atan_tab = 32'd1335087;
         10:      atan_tab = 32'd667544;
         11:      atan_tab = 32'd333772;
         12:      atan_tab = 32'd166886;
         13:      atan_tab = 32'd83443;
         14:      atan_tab = 32'd41722;
         15:      atan_tab = 32'd20861;
         default: atan_tab = '0;  // Below the phase resolution
      endcase
   endfunction

   duc_pkg::phase_t      phase;
   logic                 flip;  // Angle in the left half plane
   logic signed [XW-1:0] x [NS+1];
   logic signed [XW-1:0] y [NS+1];
   logic signed [31:0]   z [NS+1];

   always_ff @(posedge clk) begin
      if (rst)
         phase <= '0;
      else
         phase <= cfg.enable ? phase + cfg.phase_inc : '0;
   end

   assign flip = phase[31] ^ phase[30];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int k = 0; k <= NS; k++) begin
            x[k] <= '0;
            y[k] <= '0;
            z[k] <= '0;
         end
      end else begin
         // Fold by 180 deg so the residual angle stays within +-90 deg
         x[0] <= flip ? -X_INIT : X_INIT;
         y[0] <= '0;
         z[0] <= {phase[31] ^ flip, phase[30:0]};
         for (int k = 0; k < NS; k++) begin
            if (z[k][31]) begin  // Negative residual rotates clockwise
               x[k+1] <= x[k] + (y[k] >>> k);
               y[k+1] <= y[k] - (x[k] >>> k);
               z[k+1] <= z[k] + $signed(atan_tab(k));
            end else begin
               x[k+1] <= x[k] - (y[k] >>> k);
               y[k+1] <= y[k] + (x[k] >>> k);
               z[k+1] <= z[k] - $signed(atan_tab(k));
            end
         end
      end
   end

   // Drop the fraction bits
   assign cos_o = duc_pkg::wide_t'(x[NS] >>> 2);
   assign sin_o = duc_pkg::wide_t'(y[NS] >>> 2);

endmodule

//--- logic/duc_pkg.sv
/*
 * Shared types of the up-conversion chain: baseband and wide samples,
 * NCO phase word, packed I/Q pair and settings register offsets
 */
package duc_pkg;

   // Baseband input and front-end output sample
   typedef logic signed [15:0] sample_t;

   // Interpolated signal and carrier value with 2 bits of headroom
   typedef logic signed [17:0] wide_t;

   // NCO phase word where 2^32 is the full circle
   typedef logic [31:0] phase_t;

   // I in the upper half of the word and Q in the lower half
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_t;

   // Offsets from the settings base
   typedef enum logic [7:0] {
      SR_PHASE_INC = 8'd0,   // Carrier step per clock
      SR_SCALE     = 8'd1,   // 18-bit gain with unity at 2^16
      SR_RATE      = 8'd2    // Rate exponent 0 to 6
   } set_addr_e;

endpackage

//--- logic/duc_settings.sv
/*
 * Settings register decode for phase increment, scale and rate,
 * with the rate-change pulse and the chain enable level
 */
`timescale 1ns/1ns
`include "duc_params.svh"

module duc_settings (
   input  logic        clk,
   input  logic        rst,
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,
   input  logic        run_i,
   duc_cfg_if.ctrl     cfg
);

   logic [7:0] offset;    // Address relative to the block base
   logic [2:0] rate_req;  // Requested exponent before the range clamp

   assign offset   = set_addr_i - `DUC_BASE;
   assign rate_req = set_data_i[2:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         cfg.phase_inc   <= '0;
         cfg.scale       <= '0;  // Silent until software sets a gain
         cfg.rate_log2   <= '0;
         cfg.rate_change <= 1'b0;
      end else begin
         cfg.rate_change <= 1'b0;  // Pulse lasts one cycle
         if (set_stb_i) begin
            case (duc_pkg::set_addr_e'(offset))
               duc_pkg::SR_PHASE_INC: cfg.phase_inc <= set_data_i;
               duc_pkg::SR_SCALE:     cfg.scale     <= set_data_i[17:0];
               duc_pkg::SR_RATE: begin
                  // Exponent 7 would overflow the CIC guard bits
                  if (rate_req > 3'(`DUC_MAX_LOG2))
                     cfg.rate_log2 <= 3'(`DUC_MAX_LOG2);
                  else
                     cfg.rate_log2 <= rate_req;
                  cfg.rate_change <= 1'b1;
               end
               default: ;  // Address belongs to another block
            endcase
         end
      end
   end

   // The new rate takes effect on a freshly cleared datapath
   assign cfg.enable = run_i & ~cfg.rate_change;

endmodule

//--- tb/duc_tb_tasks.svh
/*
 * Testbench helpers: settings write, typed compare tasks and a
 * real-valued reference model of mixer, gain, rounding and clamp
 */
`ifndef DUC_TB_TASKS_SVH
`define DUC_TB_TASKS_SVH

localparam real PI = 3.14159265358979;

// One-cycle write on the settings bus
task automatic write_reg(input duc_pkg::set_addr_e reg_addr, input logic [31:0] value);
   @(posedge clk);
   set_stb_i  <= 1'b1;
   set_addr_i <= 8'(`DUC_BASE + reg_addr);  // Offset on top of the block base
   set_data_i <= value;
   @(posedge clk);
   set_stb_i  <= 1'b0;
endtask

// Output sample check with a tolerance in LSB
task automatic compare_sample(input string name, input duc_pkg::sample_t actual,
                              input duc_pkg::sample_t expected, input int tol);
   int diff;
   diff = int'(actual) - int'(expected);
   if (diff > tol || diff < -tol) begin
      $display("** Error at %0t ns: %s = %0d, expected %0d (+-%0d)",
               $time, name, actual, expected, tol);
      errors++;
   end
endtask

// Exact check of strobe counts and periods
task automatic compare_count(input string name, input int actual, input int expected);
   if (actual != expected) begin
      $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
      errors++;
   end
endtask

// Round to nearest, then clamp like the front end
function automatic duc_pkg::sample_t to_sample(input real v);
   if (v >= 32767.0)
      return 16'sh7fff;
   if (v <= -32768.0)
      return 16'sh8000;
   return duc_pkg::sample_t'($rtoi(v >= 0.0 ? v + 0.5 : v - 0.5));
endfunction

// One component of (I + jQ) rotated by step and weighted by scale / 2^16
function automatic real ref_component(input real i_in, input real q_in, input real scale,
                                      input duc_pkg::phase_t step, input bit q_part);
   real st;
   real ang;
   st  = step;                                 // Unsigned phase word
   ang = 2.0 * PI * st / 4294967296.0;         // Full circle is 2^32
   if (q_part)
      return (i_in * $sin(ang) + q_in * $cos(ang)) * scale / 65536.0;
   return (i_in * $cos(ang) - q_in * $sin(ang)) * scale / 65536.0;
endfunction

function automatic duc_pkg::sample_t ref_rotate(input real i_in, input real q_in,
      input real scale, input duc_pkg::phase_t step, input bit q_part);
   return to_sample(ref_component(i_in, q_in, scale, step, q_part));
endfunction

// Expected output magnitude
function automatic duc_pkg::sample_t ref_magnitude(input real i_in, input real q_in,
      input real scale, input duc_pkg::phase_t step);
   real ri;
   real rq;
   ri = ref_component(i_in, q_in, scale, step, 1'b0);
   rq = ref_component(i_in, q_in, scale, step, 1'b1);
   return to_sample($sqrt(ri * ri + rq * rq));
endfunction

// Magnitude of a measured output pair
function automatic duc_pkg::sample_t pair_magnitude(input duc_pkg::sample_t i_v,
                                                    input duc_pkg::sample_t q_v);
   real ri;
   real rq;
   ri = i_v;
   rq = q_v;
   return to_sample($sqrt(ri * ri + rq * rq));
endfunction

`endif

//--- tb/tb_duc_chain.sv
/*
 * Testbench for the up-conversion chain: clock, reset, watchdog,
 * DUT and directed tests for strobes, unity path, carrier and gain
 */
`timescale 1ns/1ns
`include "duc_params.svh"

module tb_duc_chain;

   localparam int CLK_PERIOD = 4;
   localparam duc_pkg::phase_t ROT_STEP = 32'h1000_0000;  // 22.5 deg per clock
   localparam int SETTLE_MAX  = 64 + 8 * (1 << `DUC_MAX_LOG2) + 16;
   localparam int TEST_CYCLES = 64 + 7 * (256 + 16) + 3 * (SETTLE_MAX + 16)
                                + (SETTLE_MAX + 32) + (SETTLE_MAX + 64)
                                + (2 * SETTLE_MAX + 3 * 64);
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + 1000;

   logic                  clk;
   logic                  rst;
   logic                  set_stb_i;
   logic [7:0]            set_addr_i;
   logic [31:0]           set_data_i;
   logic [31:0]           sample_i;
   logic                  run_i;
   logic                  strobe_o;
   logic [`DUC_OUT_W-1:0] tx_i_o;
   logic [`DUC_OUT_W-1:0] tx_q_o;

   int     errors;
   int     tests_run;
   int     tests_passed;
   integer seed = 41;  // Fixed seed for the I/Q amplitudes

`include "duc_tb_tasks.svh"

   duc_chain dut (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .sample_i   (sample_i),
      .run_i      (run_i),
      .strobe_o   (strobe_o),
      .tx_i_o     (tx_i_o),
      .tx_q_o     (tx_q_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      $display("Watchdog expired after %0d cycles, a test is stuck", WATCHDOG_CYCLES);
      $display("Test failures found");
      $finish;
   end

   task automatic set_sample(input duc_pkg::sample_t i_v, input duc_pkg::sample_t q_v);
      @(posedge clk);
      sample_i <= {i_v, q_v};  // Held until the next call
   endtask

   // Settling time for a constant input at a given rate
   task automatic settle(input int rate_log2);
      repeat (64 + 8 * (1 << rate_log2) + 16) @(posedge clk);
   endtask

   task automatic wait_strobe(input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (!strobe_o && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!strobe_o) begin
         $display("strobe_o did not pulse within %0d cycles at %0t ns", limit, $time);
         errors++;
      end
   endtask

   // Clocks from one strobe cycle to the next
   task automatic measure_period(input int limit, output int cycles);
      @(negedge clk);
      cycles = 1;
      while (!strobe_o && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic check_output(input duc_pkg::sample_t i_v, input duc_pkg::sample_t q_v,
                               input real scale, input int cycles, input int tol);
      repeat (cycles) begin
         @(negedge clk);
         compare_sample("tx_i_o", tx_i_o, ref_rotate(i_v, q_v, scale, 0, 1'b0), tol);
         compare_sample("tx_q_o", tx_q_o, ref_rotate(i_v, q_v, scale, 0, 1'b1), tol);
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         tests_passed++;
         $display("[%0t ns] PASS %s", $time, name);
      end else begin
         $display("[%0t ns] FAIL %s", $time, name);
      end
   endtask

   task automatic test_reset_state();
      int e0;
      int pulses;
      e0     = errors;
      pulses = 0;
      repeat (32) begin  // Run still low
         @(negedge clk);
         if (strobe_o)
            pulses++;
         compare_sample("tx_i_o", tx_i_o, 0, 0);
         compare_sample("tx_q_o", tx_q_o, 0, 0);
      end
      compare_count("strobe_o pulses", pulses, 0);
      finish_test("reset state", e0);
   endtask

   task automatic test_strobe_rate();
      int e0;
      int pulses;
      e0 = errors;
      for (int r = 0; r <= `DUC_MAX_LOG2; r++) begin
         write_reg(duc_pkg::SR_RATE, r);
         repeat (8) @(posedge clk);
         pulses = 0;
         repeat (256) begin
            @(negedge clk);
            if (strobe_o)
               pulses++;
         end
         compare_count($sformatf("strobe_o pulses at rate 2^%0d", r), pulses, 256 >> r);
      end
      finish_test("strobe rate", e0);
   endtask

   task automatic test_unity();
      int e0;
      int r;
      duc_pkg::sample_t si;
      duc_pkg::sample_t sq;
      e0 = errors;
      write_reg(duc_pkg::SR_PHASE_INC, 0);
      write_reg(duc_pkg::SR_SCALE, 32'h1_0000);
      for (int k = 0; k < 3; k++) begin
         r  = 3 * k;  // Rates 1, 8 and 64
         si = $random(seed) % 16000;
         sq = $random(seed) % 16000;
         set_sample(si, sq);
         write_reg(duc_pkg::SR_RATE, r);  // Clears CIC and phase
         settle(r);
         check_output(si, sq, 65536.0, 8, 4);
      end
      finish_test("unity path", e0);
   endtask

   task automatic test_rotation();
      int e0;
      duc_pkg::sample_t amp;
      duc_pkg::sample_t prev_i;
      duc_pkg::sample_t prev_q;
      duc_pkg::sample_t cur_i;
      duc_pkg::sample_t cur_q;
      e0  = errors;
      amp = 8000 + ({$random(seed)} % 16000);
      set_sample(amp, 0);
      write_reg(duc_pkg::SR_PHASE_INC, ROT_STEP);
      write_reg(duc_pkg::SR_RATE, 0);
      settle(0);
      @(negedge clk);
      prev_i = tx_i_o;
      prev_q = tx_q_o;
      repeat (16) begin
         @(negedge clk);
         cur_i = tx_i_o;
         cur_q = tx_q_o;
         compare_sample("tx magnitude", pair_magnitude(cur_i, cur_q),
                        ref_magnitude(amp, 0, 65536.0, ROT_STEP), 4);
         // Previous pair advanced by one phase step
         compare_sample("tx_i_o", cur_i, ref_rotate(prev_i, prev_q, 65536.0, ROT_STEP, 1'b0), 6);
         compare_sample("tx_q_o", cur_q, ref_rotate(prev_i, prev_q, 65536.0, ROT_STEP, 1'b1), 6);
         prev_i = cur_i;
         prev_q = cur_q;
      end
      finish_test("carrier rotation", e0);
   endtask

   task automatic test_gain();
      int e0;
      duc_pkg::sample_t si;
      duc_pkg::sample_t sq;
      e0 = errors;
      si = $random(seed) % 16000;  // Doubling stays inside full range
      sq = $random(seed) % 16000;
      write_reg(duc_pkg::SR_PHASE_INC, 0);
      write_reg(duc_pkg::SR_SCALE, 32'h8000);
      set_sample(si, sq);
      write_reg(duc_pkg::SR_RATE, 0);
      settle(0);
      check_output(si, sq, 32768.0, 8, 4);
      write_reg(duc_pkg::SR_SCALE, 32'h2_0000);
      repeat (8) @(posedge clk);  // Mixer latency only
      check_output(si, sq, 131072.0, 8, 4);
      set_sample(20000, -20000);  // Near 4x gain overflows both rails
      write_reg(duc_pkg::SR_SCALE, 32'h3_FFFF);
      settle(0);
      check_output(20000, -20000, 262143.0, 8, 0);
      finish_test("gain and saturation", e0);
   endtask

   task automatic test_rate_change();
      int e0;
      int period;
      duc_pkg::sample_t si;
      duc_pkg::sample_t sq;
      e0 = errors;
      si = $random(seed) % 16000;
      sq = $random(seed) % 16000;
      write_reg(duc_pkg::SR_SCALE, 32'h1_0000);
      set_sample(si, sq);
      write_reg(duc_pkg::SR_RATE, 0);  // Strobe high on every cycle
      settle(0);
      wait_strobe(16);
      write_reg(duc_pkg::SR_RATE, 5);  // While run stays high
      @(negedge clk);
      @(negedge clk);                  // Counter cleared by the enable drop
      compare_count("strobe_o after rate write", strobe_o, 0);
      wait_strobe(8);
      measure_period(64, period);
      compare_count("strobe_o period", period, 32);
      settle(5);
      check_output(si, sq, 65536.0, 8, 4);
      finish_test("rate change while running", e0);
   endtask

   initial begin
      rst          = 1'b1;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      sample_i     = '0;
      run_i        = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_passed = 0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      test_reset_state();
      write_reg(duc_pkg::SR_SCALE, 32'h1_0000);
      @(posedge clk);
      run_i <= 1'b1;
      test_strobe_rate();
      test_unity();
      test_rotation();
      test_gain();
      test_rate_change();

      $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
               tests_run, tests_passed, tests_run - tests_passed, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule
